//--- all.f
hw/snake_pkg.sv
hw/snake_ctrl.sv
hw/heading_select.sv
hw/cell_age_board.sv
hw/apple_picker.sv
hw/sense_gen.sv
hw/snake_game_top.sv
dv/tb_clock.sv
dv/snake_game_assertions.sv
dv/snake_game_tb.sv

//--- dv/snake_game_assertions.sv
`timescale 1ns/1ns

module snake_game_assertions import snake_pkg::*; (
   input logic clk,
   input logic rst,
   input logic step,
   input logic game_over,
   input logic board_update,
   input pos_t head
);

   // steps must be at least 3 cycles apart
   step_spacing: assert property (@(posedge clk) disable iff (rst)
      step |=> !step [*2])
      else $error("step strobes closer than 3 cycles");

   // a step that did not crash lands on a neighbouring cell
   head_moves_one: assert property (@(posedge clk) disable iff (rst)
      board_update && !game_over |->
         (head.row == $past(head.row) &&
          (head.col == $past(head.col) + 1'b1 || head.col + 1'b1 == $past(head.col))) ||
         (head.col == $past(head.col) &&
          (head.row == $past(head.row) + 1'b1 || head.row + 1'b1 == $past(head.row))))
      else $error("head did not move to a neighbouring cell");

   head_on_board: assert property (@(posedge clk) disable iff (rst)
      head.row < board_rows && head.col < board_cols)
      else $error("head left the board");

endmodule

bind snake_ctrl snake_game_assertions snake_game_assertions_inst (
   .clk          (clk),
   .rst          (rst),
   .step         (step),
   .game_over    (game_over),
   .board_update (board_update),
   .head         (head)
);

//--- dv/snake_game_tb.sv
`timescale 1ns/1ns

module snake_game_tb import snake_pkg::*; ();

   localparam int n_directed = 10;
   localparam int n_random = 24;
   localparam int n_final = 22;
   localparam int n_rows = n_directed + n_random + n_final;
   localparam int row_cycles = 11;
   localparam int timeout_cycles = n_rows * row_cycles + 50;

   typedef struct packed {
      logic       manual;
      logic [3:0] key;
      logic [1:0] ai;
      logic       has_exp;
      logic [4:0] exp_row;
      logic [4:0] exp_col;
      logic [1:0] exp_hd;
      logic [8:0] exp_len;
   } row_t;

   logic clk, rst, step, manual, game_over;
   logic [3:0] key;
   turn_t ai_turn;
   pos_t head;
   heading_t heading;
   age_t length;
   cell_idx_t apple;
   sense_t sense;

   row_t rows [n_rows];
   int age [num_cells];
   int m_row, m_col, m_len, cycles, errors;
   heading_t m_hd, m_req;
   logic m_over;
   logic [31:0] lcg_state;

   tb_clock tb_clock_inst (.clk(clk), .rst(rst));

   snake_game_top snake_game_top_inst (
      .clk(clk), .rst(rst), .step(step), .manual(manual), .key(key),
      .ai_turn(ai_turn), .head(head), .heading(heading), .length(length),
      .apple(apple), .game_over(game_over), .sense(sense)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic heading_t cw(heading_t h);
      case (h)
         heading_up:    return heading_right;
         heading_right: return heading_down;
         heading_down:  return heading_left;
         default:       return heading_up;
      endcase
   endfunction

   function automatic heading_t ccw(heading_t h);
      return cw(cw(cw(h)));
   endfunction

   function automatic void neighbour(input int r, input int c, input heading_t d,
                                     output int nr, output int nc);
      nr = r - (d == heading_up) + (d == heading_down);
      nc = c - (d == heading_left) + (d == heading_right);
   endfunction

   function automatic logic obstacle(int r, int c, heading_t d);
      int nr, nc;
      neighbour(r, c, d, nr, nc);
      if (nr < 0 || nr >= board_rows || nc < 0 || nc >= board_cols) return 1'b1;
      return age[nr * board_cols + nc] > 1;
   endfunction

   function automatic logic apple_seen(int r, int c, heading_t d, int a);
      int ar, ac;
      ar = a / board_cols;
      ac = a % board_cols;
      case (d)
         heading_up:   return ac == c && ar < r;
         heading_down: return ac == c && ar > r;
         heading_left: return ar == r && ac < c;
         default:      return ar == r && ac > c;
      endcase
   endfunction

   function automatic sense_t model_sense(int a);
      sense_t s;
      s.apple_front = apple_seen(m_row, m_col, m_hd, a);
      s.apple_left = apple_seen(m_row, m_col, ccw(m_hd), a);
      s.apple_right = apple_seen(m_row, m_col, cw(m_hd), a);
      s.obst_front = obstacle(m_row, m_col, m_hd);
      s.obst_left = obstacle(m_row, m_col, ccw(m_hd));
      s.obst_right = obstacle(m_row, m_col, cw(m_hd));
      return s;
   endfunction

   // registered request as the keys or the turn ask for it
   function automatic void select_req(row_t r);
      heading_t cand;
      logic valid;
      valid = 1'b1;
      cand = m_hd;
      if (r.manual) begin
         case (r.key)
            4'b0001: cand = heading_up;
            4'b0010: cand = heading_down;
            4'b0100: cand = heading_left;
            4'b1000: cand = heading_right;
            default: valid = 1'b0;
         endcase
      end else begin
         case (r.ai)
            2'd0:    cand = cw(m_hd);
            2'd1:    cand = m_hd;
            2'd2:    cand = ccw(m_hd);
            default: valid = 1'b0;
         endcase
      end
      if (valid) m_req = (cand == cw(cw(m_hd))) ? m_hd : cand;
   endfunction

   function automatic logic model_step(int apple_now);
      int nr, nc;
      logic ate;
      ate = 1'b0;
      if (m_over) return 1'b0;
      m_hd = m_req;
      neighbour(m_row, m_col, m_hd, nr, nc);
      if (obstacle(m_row, m_col, m_hd)) begin
         m_over = 1'b1;
      end else begin
         m_row = nr;
         m_col = nc;
         if (nr * board_cols + nc == apple_now) begin
            ate = 1'b1;
            m_len++;
         end
      end
      for (int i = 0; i < num_cells; i++) begin
         if (i == m_row * board_cols + m_col) age[i] = m_len;
         else if (age[i] > 0 && !ate) age[i]--;
      end
      return ate;
   endfunction

   function automatic row_t mk(logic man, logic [3:0] k, logic [1:0] ai,
                               int er, int ec, heading_t eh, int el);
      return '{man, k, ai, 1'b1, er[4:0], ec[4:0], eh, el[8:0]};
   endfunction

   task automatic check_value(string what, int got, int exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL t=%0t %s: got %0d expected %0d", $time, what, got, exp);
         $display("Errors found");
         $fatal(1);
      end
   endtask

   task automatic build_table();
      logic [31:0] r;
      rows[0] = mk(1, 4'b1000, 3, 5, 6, heading_right, 1);
      rows[1] = mk(1, 4'b0100, 3, 5, 7, heading_right, 1);
      rows[2] = mk(1, 4'b0001, 3, 4, 7, heading_up, 1);
      rows[3] = mk(0, 4'b0000, 0, 4, 8, heading_right, 1);
      rows[4] = mk(0, 4'b0000, 2, 3, 8, heading_up, 1);
      rows[5] = mk(0, 4'b0000, 1, 2, 8, heading_up, 1);
      rows[6] = mk(0, 4'b0000, 0, 2, 9, heading_right, 1);
      rows[7] = mk(0, 4'b0000, 2, 1, 9, heading_up, 1);
      rows[8] = mk(1, 4'b0001, 3, 0, 9, heading_up, 1);
      rows[9] = mk(1, 4'b1000, 3, 0, 10, heading_right, 2);
      for (int i = n_directed; i < n_rows; i++) begin
         r = lcg_next();
         rows[i] = '0;
         rows[i].manual = 1'b1;
         rows[i].ai = 2'd3;
         if (i >= n_directed + n_random) rows[i].key = 4'b0001;
         else if (r[23:21] == 3'd0) rows[i].key = 4'b0110;
         else rows[i].key = 4'b0001 << r[18:17];
      end
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
         $display("Errors found");
         $fatal(1);
      end
   end

   initial begin
      int old_apple;
      logic ate;
      step = 1'b0;
      manual = 1'b1;
      key = 4'b0000;
      ai_turn = turn_none;
      cycles = 0;
      errors = 0;
      lcg_state = 32'h38e4;
      m_row = 5;
      m_col = 5;
      m_len = 1;
      m_hd = heading_up;
      m_req = heading_up;
      m_over = 1'b0;
      foreach (age[i]) age[i] = 0;
      build_table();
      @(negedge rst);
      @(posedge clk);
      #1;
      check_value("reset head", head, {5'd5, 5'd5});
      check_value("reset heading", heading, heading_up);
      check_value("reset length", length, 1);
      check_value("reset apple", apple, 10);
      check_value("reset game_over", game_over, 0);
      check_value("reset sense", sense, 0);
      for (int i = 0; i < n_rows; i++) begin
         manual = rows[i].manual;
         key = rows[i].key;
         ai_turn = turn_t'(rows[i].ai);
         select_req(rows[i]);
         repeat (2) @(posedge clk);
         #1 step = 1'b1;
         old_apple = apple;
         ate = model_step(old_apple);
         @(posedge clk);
         #1;
         step = 1'b0;
         manual = 1'b1;
         key = 4'b0000;
         repeat (7) @(posedge clk);
         #1;
         check_value($sformatf("row %0d head", i), head, {m_row[4:0], m_col[4:0]});
         check_value($sformatf("row %0d heading", i), heading, m_hd);
         check_value($sformatf("row %0d length", i), length, m_len);
         check_value($sformatf("row %0d game_over", i), game_over, m_over);
         check_value($sformatf("row %0d sense", i), sense, model_sense(apple));
         if (rows[i].has_exp) begin
            check_value($sformatf("row %0d table head", i), head,
                        {rows[i].exp_row, rows[i].exp_col});
            check_value($sformatf("row %0d table heading", i), heading, rows[i].exp_hd);
            check_value($sformatf("row %0d table length", i), length, rows[i].exp_len);
         end
         if (ate) begin
            check_value($sformatf("row %0d apple moved", i), apple != old_apple, 1);
            check_value($sformatf("row %0d apple row even", i), (apple / board_cols) % 2, 0);
            check_value($sformatf("row %0d apple cell free", i), age[apple], 0);
         end
      end
      check_value("final game_over", game_over, 1);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // two full cycles of reset
   initial begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      #1 rst = 1'b0;
   end

endmodule

//--- hw/apple_picker.sv
`timescale 1ns/1ns

module apple_picker import snake_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  cell_map_t occupied_map,
   input  cell_idx_t apple,
   output cell_idx_t next_apple
);

   logic [8:0] lfsr;
   cell_idx_t  cand;
   coord_t     cand_row;
   logic       legal;

   always_comb begin
      cand = cell_idx_t'(lfsr % num_cells);
      cand_row = coord_t'(cand / board_cols);
      // free cell, not the current apple, even row only
      legal = !occupied_map[cand] && (cand != apple) && !cand_row[0];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr <= lfsr_seed;
         next_apple <= first_apple;
      end else begin
         lfsr <= {lfsr[7:0], ^(lfsr & lfsr_taps)};
         if (legal) begin
            next_apple <= cand;
         end
      end
   end

endmodule

//--- hw/cell_age_board.sv
`timescale 1ns/1ns

module cell_age_board import snake_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      board_update,
   input  logic      ate,
   input  pos_t      head,
   input  age_t      length,
   output cell_map_t body_map,
   output cell_map_t occupied_map
);

   age_t      age [num_cells];
   cell_idx_t head_idx;

   assign head_idx = cell_of(head);

   // each cell counts down the steps until the tail leaves it
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < num_cells; i++) begin
            age[i] <= '0;
         end
      end else if (board_update) begin
         for (int i = 0; i < num_cells; i++) begin
            if (head_idx == cell_idx_t'(i)) begin
               age[i] <= length;
            end else if (age[i] != '0 && !ate) begin
               age[i] <= age[i] - 1'b1;
            end
         end
      end
   end

   // age 1 is the tail, which moves away on the next step
   always_comb begin
      for (int i = 0; i < num_cells; i++) begin
         body_map[i] = age[i] > age_t'(1);
         occupied_map[i] = age[i] != '0;
      end
   end

endmodule

//--- hw/heading_select.sv
`timescale 1ns/1ns

module heading_select import snake_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       manual,
   input  logic [3:0] key,
   input  turn_t      ai_turn,
   input  heading_t   cur_heading,
   output heading_t   req_heading
);

   heading_t cand;
   heading_t reverse;
   logic     cand_valid;

   // up/down and left/right differ only in bit 0
   assign reverse = heading_t'(cur_heading ^ 2'b01);

   always_comb begin
      cand = cur_heading;
      cand_valid = 1'b1;
      if (manual) begin
         case (key)
            4'b0001: cand = heading_up;
            4'b0010: cand = heading_down;
            4'b0100: cand = heading_left;
            4'b1000: cand = heading_right;
            default: cand_valid = 1'b0;
         endcase
      end else begin
         // relative turn to absolute heading
         case (ai_turn)
            turn_right: cand = rotate_cw(cur_heading);
            turn_left:  cand = rotate_ccw(cur_heading);
            straight:   cand = cur_heading;
            default:    cand_valid = 1'b0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         req_heading <= heading_up;
      end else if (cand_valid) begin
         if (cand == reverse) begin
            req_heading <= cur_heading;
         end else begin
            req_heading <= cand;
         end
      end
   end

endmodule

//--- hw/sense_gen.sv
`timescale 1ns/1ns

module sense_gen import snake_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  pos_t      head,
   input  heading_t  cur_heading,
   input  cell_idx_t apple,
   input  cell_map_t body_map,
   output sense_t    sense
);

   coord_t     apple_row;
   coord_t     apple_col;
   logic [3:0] apple_dir;
   logic [3:0] obst_dir;
   heading_t   left_hd;
   heading_t   right_hd;

   always_comb begin
      apple_row = coord_t'(apple / board_cols);
      apple_col = coord_t'(apple % board_cols);

      // apple seen along each absolute direction
      apple_dir[heading_up] = (apple_col == head.col) && (apple_row < head.row);
      apple_dir[heading_down] = (apple_col == head.col) && (apple_row > head.row);
      apple_dir[heading_left] = (apple_row == head.row) && (apple_col < head.col);
      apple_dir[heading_right] = (apple_row == head.row) && (apple_col > head.col);

      // wall or body right next to the head
      for (int d = 0; d < 4; d++) begin
         if (at_edge(head, heading_t'(d))) begin
            obst_dir[d] = 1'b1;
         end else begin
            obst_dir[d] = body_map[cell_of(move_pos(head, heading_t'(d)))];
         end
      end

      left_hd = rotate_ccw(cur_heading);
      right_hd = rotate_cw(cur_heading);
   end

   // rotate into the snake's own frame
   always_ff @(posedge clk) begin
      if (rst) begin
         sense <= '0;
      end else begin
         sense.apple_front <= apple_dir[cur_heading];
         sense.apple_left <= apple_dir[left_hd];
         sense.apple_right <= apple_dir[right_hd];
         sense.obst_front <= obst_dir[cur_heading];
         sense.obst_left <= obst_dir[left_hd];
         sense.obst_right <= obst_dir[right_hd];
      end
   end

endmodule

//--- hw/snake_ctrl.sv
`timescale 1ns/1ns

module snake_ctrl import snake_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      step,
   input  heading_t  req_heading,
   input  cell_map_t body_map,
   input  cell_idx_t next_apple,
   output pos_t      head,
   output heading_t  cur_heading,
   output age_t      length,
   output cell_idx_t apple,
   output logic      game_over,
   output logic      board_update,
   output logic      ate
);

   pos_t      target;
   cell_idx_t target_idx;
   logic      hit_wall;
   logic      hit_body;
   logic      step_ok;
   logic      eat;

   always_comb begin
      target = move_pos(head, req_heading);
      target_idx = cell_of(target);
      hit_wall = at_edge(head, req_heading);
      // target index is only valid on the board
      hit_body = !hit_wall && body_map[target_idx];
      step_ok = step && !game_over;
      eat = !hit_wall && !hit_body && (target_idx == apple);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         head <= start_pos;
         cur_heading <= heading_up;
         length <= age_t'(1);
         apple <= first_apple;
         game_over <= 1'b0;
         board_update <= 1'b0;
         ate <= 1'b0;
      end else begin
         board_update <= step_ok;
         ate <= step_ok && eat;
         if (step_ok) begin
            cur_heading <= req_heading;
            if (hit_wall || hit_body) begin
               // head stays where it crashed
               game_over <= 1'b1;
            end else begin
               head <= target;
            end
            if (eat) begin
               length <= length + 1'b1;
               apple <= next_apple;
            end
         end
      end
   end

endmodule

//--- hw/snake_game_top.sv
`timescale 1ns/1ns

module snake_game_top import snake_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       step,
   input  logic       manual,
   input  logic [3:0] key,
   input  turn_t      ai_turn,
   output pos_t       head,
   output heading_t   heading,
   output age_t       length,
   output cell_idx_t  apple,
   output logic       game_over,
   output sense_t     sense
);

   heading_t  req_heading;
   logic      board_update;
   logic      ate;
   cell_map_t body_map;
   cell_map_t occupied_map;
   cell_idx_t next_apple;

   snake_ctrl snake_ctrl_inst (
      .clk          (clk),
      .rst          (rst),
      .step         (step),
      .req_heading  (req_heading),
      .body_map     (body_map),
      .next_apple   (next_apple),
      .head         (head),
      .cur_heading  (heading),
      .length       (length),
      .apple        (apple),
      .game_over    (game_over),
      .board_update (board_update),
      .ate          (ate)
   );

   heading_select heading_select_inst (
      .clk         (clk),
      .rst         (rst),
      .manual      (manual),
      .key         (key),
      .ai_turn     (ai_turn),
      .cur_heading (heading),
      .req_heading (req_heading)
   );

   cell_age_board cell_age_board_inst (
      .clk          (clk),
      .rst          (rst),
      .board_update (board_update),
      .ate          (ate),
      .head         (head),
      .length       (length),
      .body_map     (body_map),
      .occupied_map (occupied_map)
   );

   apple_picker apple_picker_inst (
      .clk          (clk),
      .rst          (rst),
      .occupied_map (occupied_map),
      .apple        (apple),
      .next_apple   (next_apple)
   );

   sense_gen sense_gen_inst (
      .clk         (clk),
      .rst         (rst),
      .head        (head),
      .cur_heading (heading),
      .apple       (apple),
      .body_map    (body_map),
      .sense       (sense)
   );

endmodule

//--- hw/snake_pkg.sv
package snake_pkg;

   localparam int board_rows = 20;
   localparam int board_cols = 20;
   localparam int num_cells = board_rows * board_cols;

   typedef logic [8:0] cell_idx_t;
   typedef logic [4:0] coord_t;
   typedef logic [8:0] age_t;

   typedef struct packed {
      coord_t row;
      coord_t col;
   } pos_t;

   // same encoding as the key and move decode
   typedef enum logic [1:0] {
      heading_up    = 2'b00,
      heading_down  = 2'b01,
      heading_left  = 2'b10,
      heading_right = 2'b11
   } heading_t;

   typedef enum logic [1:0] {
      turn_right = 2'd0,
      straight   = 2'd1,
      turn_left  = 2'd2,
      turn_none  = 2'd3
   } turn_t;

   typedef struct packed {
      logic apple_front;
      logic apple_left;
      logic apple_right;
      logic obst_front;
      logic obst_left;
      logic obst_right;
   } sense_t;

   typedef logic [num_cells-1:0] cell_map_t;

   localparam pos_t start_pos = '{row: 5'd5, col: 5'd5};
   localparam cell_idx_t first_apple = 9'd10;
   localparam logic [8:0] lfsr_seed = 9'h1ff;
   // x^9 + x^5 + 1
   localparam logic [8:0] lfsr_taps = 9'h110;

   function automatic cell_idx_t cell_of(pos_t p);
      return cell_idx_t'(p.row * board_cols + p.col);
   endfunction

   // true when one move in h would leave the board
   function automatic logic at_edge(pos_t p, heading_t h);
      case (h)
         heading_up:   return p.row == '0;
         heading_down: return p.row == coord_t'(board_rows - 1);
         heading_left: return p.col == '0;
         default:      return p.col == coord_t'(board_cols - 1);
      endcase
   endfunction

   function automatic pos_t move_pos(pos_t p, heading_t h);
      pos_t n;
      n = p;
      case (h)
         heading_up:   n.row = p.row - 1'b1;
         heading_down: n.row = p.row + 1'b1;
         heading_left: n.col = p.col - 1'b1;
         default:      n.col = p.col + 1'b1;
      endcase
      return n;
   endfunction

   function automatic heading_t rotate_cw(heading_t h);
      case (h)
         heading_up:   return heading_right;
         heading_right: return heading_down;
         heading_down: return heading_left;
         default:      return heading_up;
      endcase
   endfunction

   function automatic heading_t rotate_ccw(heading_t h);
      case (h)
         heading_up:   return heading_left;
         heading_left: return heading_down;
         heading_down: return heading_right;
         default:      return heading_up;
      endcase
   endfunction

endpackage
